//--- verilog/updi_pkg.sv
// UPDI wire protocol constants: sync and ACK characters, opcodes, CS addresses, key, sizes
`default_nettype none

package updi_pkg;

	typedef logic [7:0] updi_byte_t;

	// characters on the wire
	localparam updi_byte_t updi_sync = 8'h55;
	localparam updi_byte_t updi_ack = 8'h40;

	// opcode bases, the pointer, size or CS address fields are or-ed in
	localparam updi_byte_t op_lds = 8'h00;
	localparam updi_byte_t op_ld = 8'h20;
	localparam updi_byte_t op_st = 8'h60;
	localparam updi_byte_t op_ldcs = 8'h80;
	localparam updi_byte_t op_stcs = 8'hc0;
	localparam updi_byte_t op_repeat = 8'ha0;
	localparam updi_byte_t op_key = 8'he0;

	// control/status space
	localparam logic [3:0] cs_status_a = 4'h0;
	localparam logic [3:0] cs_key_status = 4'h7;
	localparam logic [3:0] cs_reset_req = 4'h8;
	localparam logic [3:0] cs_sys_status = 4'hb;

	// written to reset_req to request a system reset
	localparam updi_byte_t reset_signature = 8'h59;

	// "NVMProg " key, byte 0 in bits 7:0 goes out first
	localparam logic [63:0] key_nvmprog = 64'h4e56_4d50_726f_6720;

	// signature row in the data space
	localparam logic [15:0] sig_base = 16'h1100;

	// longest data field and longest response of one command
	localparam int max_cmd_bytes = 8;
	localparam int max_rsp_bytes = 3;

	// byte counts carried with a command
	typedef logic [$clog2(max_cmd_bytes + 1)-1:0] cmd_len_t;
	typedef logic [$clog2(max_rsp_bytes + 1)-1:0] rsp_len_t;

endpackage

`default_nettype wire

//--- verilog/prog_pkg.sv
// programming session definitions: step enumeration, parameter defaults, device ID type
`default_nettype none

package prog_pkg;

	// session steps in the order a clean session walks them
	typedef enum logic [3:0] {
		step_idle,
		step_dbreak,
		step_status,
		step_key,
		step_key_status,
		step_rst_set,
		step_rst_delay,
		step_rst_clear,
		step_sys_poll,
		step_sys_delay,
		step_ptr,
		step_repeat,
		step_read
	} prog_step_t;

	localparam int default_delay_clks = 100;
	localparam int default_timeout_clks = 200;

	// three signature bytes, first received byte on top
	typedef logic [23:0] device_id_t;

endpackage

`default_nettype wire

//--- verilog/updi_cmd_if.sv
// command channel from the session sequencer to the UPDI frame engines
`default_nettype none

interface updi_cmd_if
	import updi_pkg::*;
();
	logic start;
	updi_byte_t opcode;
	updi_byte_t [max_cmd_bytes-1:0] data;
	cmd_len_t data_len;
	rsp_len_t rsp_len;
	// an ACK follows the last data byte
	logic wait_ack;

	logic tx_done;
	logic rsp_done;
	updi_byte_t [max_rsp_bytes-1:0] rsp;
	logic fault;

	modport seq (output start, opcode, data, data_len, rsp_len, wait_ack,
		input tx_done, rsp_done, rsp, fault);
	modport tx (input start, opcode, data, data_len, output tx_done);
	modport rx (input start, rsp_len, wait_ack, tx_done, output rsp_done, rsp, fault);

endinterface

`default_nettype wire

//--- verilog/updi_frame_tx.sv
// UPDI frame transmitter: sync, opcode and data bytes into the UART transmit FIFO
`default_nettype none

module updi_frame_tx
	import updi_pkg::*;
(
	input logic clk,
	input logic rst,
	updi_cmd_if.tx cmd,
	input logic tx_full,
	output updi_byte_t tx_data,
	output logic tx_wr_en
);
	// byte index 0 is sync, 1 is the opcode, data follows
	localparam int idx_w = $clog2(max_cmd_bytes + 2);

	logic active;
	logic [idx_w-1:0] idx;
	logic [$clog2(max_cmd_bytes)-1:0] data_idx;
	logic last;
	updi_byte_t opcode_q;
	updi_byte_t [max_cmd_bytes-1:0] data_q;
	cmd_len_t len_q;

	// under back-pressure the index holds, so the frame just stalls
	assign tx_wr_en = active && !tx_full;
	assign last = (idx == idx_w'(len_q) + idx_w'(1));
	assign data_idx = $clog2(max_cmd_bytes)'(idx - idx_w'(2));

	always_comb begin
		if (idx == '0) begin
			tx_data = updi_sync;
		end else if (idx == idx_w'(1)) begin
			tx_data = opcode_q;
		end else begin
			tx_data = data_q[data_idx];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			idx <= '0;
			cmd.tx_done <= 1'b0;
		end else begin
			cmd.tx_done <= 1'b0;
			if (cmd.start) begin
				active <= 1'b1;
				idx <= '0;
			end else if (tx_wr_en) begin
				idx <= idx + 1'b1;
				if (last) begin
					active <= 1'b0;
					cmd.tx_done <= 1'b1;
				end
			end
		end
	end

	// command is captured once, the sequencer may move on
	always_ff @(posedge clk) begin
		if (cmd.start) begin
			opcode_q <= cmd.opcode;
			data_q <= cmd.data;
			len_q <= cmd.data_len;
		end
	end

	a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
		tx_wr_en |-> !tx_full);

endmodule

`default_nettype wire

//--- verilog/updi_frame_rx.sv
// UPDI response receiver: ACK check or response bytes from the UART receive FIFO, with timeout
`default_nettype none

module updi_frame_rx
	import updi_pkg::*;
	import prog_pkg::*;
#(
	parameter int TIMEOUT_CLKS = default_timeout_clks
) (
	input logic clk,
	input logic rst,
	updi_cmd_if.rx cmd,
	input updi_byte_t rx_data,
	input logic rx_empty,
	output logic rx_rd_en
);
	localparam int tmr_w = $clog2(TIMEOUT_CLKS + 1);

	typedef enum logic [1:0] {rx_idle, rx_armed, rx_read} rx_state_t;

	rx_state_t state;
	logic ack_mode;
	rsp_len_t need;
	rsp_len_t got;
	// a read was issued, its byte is on rx_data now
	logic pend;
	logic [tmr_w-1:0] tmr;
	logic timeout;

	assign rx_rd_en = (state == rx_read) && !pend && !rx_empty;
	assign timeout = (state == rx_read) && !pend && !rx_rd_en &&
		(tmr == tmr_w'(TIMEOUT_CLKS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rx_idle;
			pend <= 1'b0;
			got <= '0;
			tmr <= '0;
			cmd.rsp_done <= 1'b0;
			cmd.fault <= 1'b0;
		end else begin
			cmd.rsp_done <= 1'b0;
			cmd.fault <= 1'b0;
			pend <= rx_rd_en;
			tmr <= rx_rd_en ? '0 : tmr + 1'b1;
			if (cmd.start) begin
				state <= rx_armed;
				pend <= 1'b0;
			end else if (state == rx_armed && cmd.tx_done) begin
				// nothing expected back, the command ends at tx_done
				state <= (ack_mode || need != '0) ? rx_read : rx_idle;
				got <= '0;
				tmr <= '0;
			end else if (state == rx_read && pend) begin
				got <= got + 1'b1;
				if (ack_mode) begin
					cmd.rsp_done <= (rx_data == updi_ack);
					cmd.fault <= (rx_data != updi_ack);
					state <= rx_idle;
				end else if (got == need - 1'b1) begin
					cmd.rsp_done <= 1'b1;
					state <= rx_idle;
				end
			end else if (timeout) begin
				cmd.fault <= 1'b1;
				state <= rx_idle;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.start) begin
			ack_mode <= cmd.wait_ack;
			need <= cmd.rsp_len;
		end
		if (state == rx_read && pend && !ack_mode) begin
			cmd.rsp[got] <= rx_data;
		end
	end

	a_no_read_when_empty: assert property (@(posedge clk) disable iff (rst)
		rx_rd_en |-> !rx_empty);

endmodule

`default_nettype wire

//--- verilog/prog_sequencer.sv
// session FSM: command table, status checks, reset delay counter and device ID register
`default_nettype none

module prog_sequencer
	import updi_pkg::*;
	import prog_pkg::*;
#(
	parameter int DELAY_CLKS = default_delay_clks
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic phy_error,
	input logic double_break_done,
	updi_cmd_if.seq cmd,
	output logic busy,
	output logic done,
	output logic fault,
	output device_id_t device_id,
	output logic double_break_start
);
	localparam int cnt_w = $clog2(DELAY_CLKS + 1);

	prog_step_t step;
	prog_step_t next_n;
	// command issued in this step, or double break requested
	logic issued;
	logic [cnt_w-1:0] delay_cnt;
	logic is_cmd_step;
	logic check_ok;
	logic cmd_done;
	logic restart;
	updi_byte_t opcode_n;
	updi_byte_t [max_cmd_bytes-1:0] data_n;
	cmd_len_t data_len_n;
	rsp_len_t rsp_len_n;
	logic wait_ack_n;

	always_comb begin
		opcode_n = op_ldcs;
		data_n = '0;
		data_len_n = '0;
		rsp_len_n = '0;
		wait_ack_n = 1'b0;
		is_cmd_step = 1'b1;
		check_ok = 1'b1;
		next_n = step_idle;
		case (step)
			step_status: begin
				opcode_n = op_ldcs | updi_byte_t'(cs_status_a);
				rsp_len_n = rsp_len_t'(1);
				check_ok = (cmd.rsp[0] != '0);
				next_n = step_key;
			end
			step_key: begin
				opcode_n = op_key;
				data_n = key_nvmprog;
				data_len_n = cmd_len_t'(max_cmd_bytes);
				next_n = step_key_status;
			end
			step_key_status: begin
				opcode_n = op_ldcs | updi_byte_t'(cs_key_status);
				rsp_len_n = rsp_len_t'(1);
				// NVMPROG key accepted
				check_ok = cmd.rsp[0][4];
				next_n = step_rst_set;
			end
			step_rst_set, step_rst_clear: begin
				opcode_n = op_stcs | updi_byte_t'(cs_reset_req);
				data_n[0] = (step == step_rst_set) ? reset_signature : 8'h00;
				data_len_n = cmd_len_t'(1);
				next_n = (step == step_rst_set) ? step_rst_delay : step_sys_poll;
			end
			step_sys_poll: begin
				opcode_n = op_ldcs | updi_byte_t'(cs_sys_status);
				rsp_len_n = rsp_len_t'(1);
				// NVMPROG mode not yet entered, poll again later
				next_n = cmd.rsp[0][3] ? step_ptr : step_sys_delay;
			end
			step_ptr: begin
				// ST ptr, word address
				opcode_n = op_st | 8'h09;
				data_n[0] = sig_base[7:0];
				data_n[1] = sig_base[15:8];
				data_len_n = cmd_len_t'(2);
				wait_ack_n = 1'b1;
				next_n = step_repeat;
			end
			step_repeat: begin
				opcode_n = op_repeat;
				data_n[0] = updi_byte_t'(max_rsp_bytes - 1);
				data_len_n = cmd_len_t'(1);
				next_n = step_read;
			end
			step_read: begin
				// LD *ptr++, byte
				opcode_n = op_ld | 8'h04;
				rsp_len_n = rsp_len_t'(max_rsp_bytes);
				next_n = step_idle;
			end
			default: is_cmd_step = 1'b0;
		endcase
	end

	assign cmd_done = is_cmd_step && issued &&
		((cmd.tx_done && cmd.rsp_len == '0 && !cmd.wait_ack) || cmd.rsp_done);
	assign restart = busy &&
		(phy_error || (cmd.fault && step != step_dbreak) || (cmd_done && !check_ok));

	always_ff @(posedge clk) begin
		if (rst) begin
			step <= step_idle;
			issued <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			fault <= 1'b0;
			double_break_start <= 1'b0;
			cmd.start <= 1'b0;
			delay_cnt <= '0;
		end else begin
			done <= 1'b0;
			fault <= 1'b0;
			double_break_start <= 1'b0;
			cmd.start <= 1'b0;
			if (restart) begin
				fault <= 1'b1;
				step <= step_dbreak;
				issued <= 1'b0;
			end else if (is_cmd_step && !issued) begin
				cmd.start <= 1'b1;
				issued <= 1'b1;
			end else begin
				case (step)
					step_idle: begin
						if (start) begin
							busy <= 1'b1;
							step <= step_dbreak;
						end
					end
					step_dbreak: begin
						if (!issued) begin
							double_break_start <= 1'b1;
							issued <= 1'b1;
						end else if (double_break_done) begin
							step <= step_status;
							issued <= 1'b0;
						end
					end
					step_rst_delay, step_sys_delay: begin
						if (delay_cnt == '0) begin
							step <= (step == step_rst_delay) ? step_rst_clear : step_sys_poll;
						end else begin
							delay_cnt <= delay_cnt - 1'b1;
						end
					end
					default: begin
						if (cmd_done) begin
							step <= next_n;
							issued <= 1'b0;
							delay_cnt <= cnt_w'(DELAY_CLKS - 1);
							if (step == step_read) begin
								busy <= 1'b0;
								done <= 1'b1;
							end
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (is_cmd_step && !issued) begin
			cmd.opcode <= opcode_n;
			cmd.data <= data_n;
			cmd.data_len <= data_len_n;
			cmd.rsp_len <= rsp_len_n;
			cmd.wait_ack <= wait_ack_n;
		end
		if (cmd_done && step == step_read && !restart) begin
			device_id <= {cmd.rsp[0], cmd.rsp[1], cmd.rsp[2]};
		end
	end

	// one command in flight until the engines complete it or the session restarts
	a_single_cmd: assert property (@(posedge clk) disable iff (rst)
		cmd.start && !restart |=> !cmd.start throughout (cmd_done || restart)[->1]);

	a_done_clean: assert property (@(posedge clk) disable iff (rst)
		done |-> !fault && !busy);

endmodule

`default_nettype wire

//--- verilog/updi_programmer.sv
// UPDI programmer top level: sequencer and frame engines on one command channel
`default_nettype none

module updi_programmer
	import updi_pkg::*;
	import prog_pkg::*;
#(
	parameter int DELAY_CLKS = default_delay_clks,
	parameter int TIMEOUT_CLKS = default_timeout_clks
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic phy_error,
	input logic tx_full,
	input updi_byte_t rx_data,
	input logic rx_empty,
	input logic double_break_done,
	output logic busy,
	output logic done,
	output logic fault,
	output device_id_t device_id,
	output updi_byte_t tx_data,
	output logic tx_wr_en,
	output logic rx_rd_en,
	output logic double_break_start
);
	updi_cmd_if cmd ();

	prog_sequencer #(
		.DELAY_CLKS(DELAY_CLKS)
	) i_sequencer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.phy_error(phy_error),
		.double_break_done(double_break_done),
		.cmd(cmd.seq),
		.busy(busy),
		.done(done),
		.fault(fault),
		.device_id(device_id),
		.double_break_start(double_break_start)
	);

	updi_frame_tx i_frame_tx (
		.clk(clk),
		.rst(rst),
		.cmd(cmd.tx),
		.tx_full(tx_full),
		.tx_data(tx_data),
		.tx_wr_en(tx_wr_en)
	);

	updi_frame_rx #(
		.TIMEOUT_CLKS(TIMEOUT_CLKS)
	) i_frame_rx (
		.clk(clk),
		.rst(rst),
		.cmd(cmd.rx),
		.rx_data(rx_data),
		.rx_empty(rx_empty),
		.rx_rd_en(rx_rd_en)
	);

endmodule

`default_nettype wire

//--- tests/updi_target_model.sv
// behavioral UPDI target: frame decoder, CS register answers, signature row and response queue
`default_nettype none

module updi_target_model #(
	parameter logic [7:0] SIG0 = 8'h1e,
	parameter logic [7:0] SIG1 = 8'h96,
	parameter logic [7:0] SIG2 = 8'h51
) (
	input logic clk,
	input logic rst,
	input logic [7:0] tx_data,
	input logic tx_wr_en,
	input logic rx_rd_en,
	input logic double_break_start,
	input int poll_fails,
	input logic mute_key_status,
	output logic [7:0] rx_data,
	output logic rx_empty,
	output logic double_break_done
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0] rsp_q[$];
	// opcode first, then the data bytes of the frame in progress
	logic [7:0] frame[$];
	logic in_frame;
	logic rd_q;
	logic [15:0] ptr;
	int reps;
	int polls_failed;
	int db_cnt;

	// data bytes that follow each opcode of the command table
	function automatic int data_bytes(input logic [7:0] op);
		case (op[7:5])
			3'b011: return 2;
			3'b101: return 1;
			3'b110: return 1;
			3'b111: return 8;
			default: return 0;
		endcase
	endfunction

	function automatic logic [7:0] sig_byte(input logic [15:0] addr);
		case (addr)
			16'h1100: return SIG0;
			16'h1101: return SIG1;
			16'h1102: return SIG2;
			default: return 8'hff;
		endcase
	endfunction

	task automatic answer_frame();
		logic [7:0] op;
		op = frame[0];
		case (op[7:5])
			// LDCS
			3'b100: begin
				case (op[3:0])
					4'h0: rsp_q.push_back(8'h30);
					4'h7: begin
						if (!mute_key_status) begin
							rsp_q.push_back(8'h10);
						end
					end
					4'hb: begin
						// NVMPROG mode not entered yet
						if (polls_failed < poll_fails) begin
							rsp_q.push_back(8'h00);
							polls_failed++;
						end else begin
							rsp_q.push_back(8'h08);
						end
					end
					default: rsp_q.push_back(8'h00);
				endcase
			end
			// STCS, a new reset request starts the NVMPROG entry over
			3'b110: begin
				if (op[3:0] == 4'h8 && frame[1] == 8'h59) begin
					polls_failed = 0;
				end
			end
			// ST ptr with a word address, ACK after the data
			3'b011: begin
				ptr = {frame[2], frame[1]};
				rsp_q.push_back(8'h40);
			end
			3'b101: reps = frame[1] + 1;
			// LD *ptr++ byte
			3'b001: begin
				repeat (reps) begin
					rsp_q.push_back(sig_byte(ptr));
					ptr++;
				end
				reps = 1;
			end
			default: ;
		endcase
	endtask

	initial begin
		rx_data = 8'h00;
		rx_empty = 1'b1;
		double_break_done = 1'b0;
		rd_q = 1'b0;
		in_frame = 1'b0;
		ptr = 16'h0000;
		reps = 1;
		polls_failed = 0;
		db_cnt = 0;
	end

	always @(posedge clk) begin
		rd_q = rx_rd_en;
		if (rst) begin
			rsp_q.delete();
			frame.delete();
			in_frame = 1'b0;
			reps = 1;
			polls_failed = 0;
			db_cnt = 0;
		end else if (double_break_start) begin
			// the break resets the UPDI link, pending answers are lost
			rsp_q.delete();
			frame.delete();
			in_frame = 1'b0;
			reps = 1;
			db_cnt = 3;
		end else if (tx_wr_en) begin
			if (!in_frame) begin
				in_frame = (tx_data == 8'h55);
			end else begin
				frame.push_back(tx_data);
				if (frame.size() == data_bytes(frame[0]) + 1) begin
					answer_frame();
					frame.delete();
					in_frame = 1'b0;
				end
			end
		end
	end

	// receive FIFO side, the byte read at the last edge appears now
	always @(negedge clk) begin
		if (rd_q && rsp_q.size() != 0) begin
			rx_data = rsp_q.pop_front();
		end
		rx_empty = (rsp_q.size() == 0);
		double_break_done = 1'b0;
		if (db_cnt != 0) begin
			db_cnt--;
			double_break_done = (db_cnt == 0);
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_updi_programmer.sv
// testbench for the UPDI programmer: clock, reset, sessions, xorshift back-pressure, checks, report
`default_nettype none

module tb_updi_programmer;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int delay_clks = 40;
	localparam int timeout_clks = 64;
	localparam int n_sessions = 4;
	localparam int max_cycles = n_sessions * (20 * 40 + 4 * delay_clks + timeout_clks);
	localparam logic [7:0] sig0 = 8'h1e;
	localparam logic [7:0] sig1 = 8'h96;
	localparam logic [7:0] sig2 = 8'h51;

	logic clk;
	logic rst;
	logic start;
	logic phy_error;
	logic tx_full;
	logic [7:0] rx_data;
	logic rx_empty;
	logic double_break_done;
	logic busy;
	logic done;
	logic fault;
	logic [23:0] device_id;
	logic [7:0] tx_data;
	logic tx_wr_en;
	logic rx_rd_en;
	logic double_break_start;

	int poll_fails;
	logic mute_key_status;
	logic rand_full;
	logic started;
	logic busy_q;
	logic [31:0] rng;
	int cyc = 0;
	int wd_cnt = 0;
	int last_rd_cyc = 0;
	int done_cnt = 0;
	int fault_cnt = 0;
	int done_base = 0;
	int fault_base = 0;
	int rst_writes = 0;
	int value_errs = 0;
	int proto_errs = 0;
	logic [7:0] stream[$];
	logic [7:0] expected[$];

	updi_programmer #(
		.DELAY_CLKS(delay_clks),
		.TIMEOUT_CLKS(timeout_clks)
	) i_dut (.*);

	updi_target_model #(
		.SIG0(sig0),
		.SIG1(sig1),
		.SIG2(sig2)
	) i_target (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic value_check(input logic ok, input string msg);
		assert (ok) else begin
			value_errs++;
			$display("ERR %0t: %s", $time, msg);
		end
	endtask

	task automatic proto_fail(input string msg);
		proto_errs++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	task automatic push_frame(input logic [7:0] op, input logic [63:0] data, input int n);
		expected.push_back(8'h55);
		expected.push_back(op);
		for (int i = 0; i < n; i++) begin
			expected.push_back(data[8*i +: 8]);
		end
	endtask

	// byte stream of one clean session with k failed system status polls
	task automatic build_expected(input int k);
		expected.delete();
		push_frame(8'h80, 64'h0, 0);
		push_frame(8'he0, 64'h4e56_4d50_726f_6720, 8);
		push_frame(8'h87, 64'h0, 0);
		push_frame(8'hc8, 64'h59, 1);
		push_frame(8'hc8, 64'h00, 1);
		repeat (k + 1) begin
			push_frame(8'h8b, 64'h0, 0);
		end
		push_frame(8'h69, 64'h1100, 2);
		push_frame(8'ha0, 64'h02, 1);
		push_frame(8'h24, 64'h0, 0);
	endtask

	task automatic pulse_start();
		done_base = done_cnt;
		fault_base = fault_cnt;
		start = 1'b1;
		started = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_done();
		while (done_cnt == done_base) begin
			@(negedge clk);
		end
	endtask

	task automatic wait_fault();
		while (fault_cnt == fault_base) begin
			@(negedge clk);
		end
	endtask

	task automatic run_clean(input int k);
		build_expected(k);
		stream.delete();
		pulse_start();
		wait_done();
		value_check(stream.size() == expected.size(),
			$sformatf("stream has %0d bytes, expected %0d", stream.size(), expected.size()));
		for (int i = 0; i < stream.size() && i < expected.size(); i++) begin
			value_check(stream[i] == expected[i],
				$sformatf("stream byte %0d is %h, expected %h", i, stream[i], expected[i]));
		end
	endtask

	task automatic report_counts();
		$display("value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// transmit FIFO back-pressure
	always @(negedge clk) begin
		rng = xorshift32(rng);
		tx_full = rand_full && (rng[2:0] < 3'd3);
	end

	// sampled at the rising edge, before the DUT registers update
	always @(posedge clk) begin
		if (!rst) begin
			if (tx_wr_en) begin
				if (tx_data == 8'h8b && stream.size() != 0 && stream[$] == 8'h55) begin
					value_check(cyc - last_rd_cyc >= delay_clks,
						$sformatf("status poll %0d cycles after a response", cyc - last_rd_cyc));
				end
				if (tx_data == 8'h59 && stream.size() != 0 && stream[$] == 8'hc8) begin
					rst_writes++;
				end
				stream.push_back(tx_data);
			end
			if (rx_rd_en) begin
				last_rd_cyc = cyc;
			end
			if (fault) begin
				fault_cnt++;
			end
			if (done) begin
				done_cnt++;
				value_check(device_id == {sig0, sig1, sig2},
					$sformatf("device_id %h, expected %h", device_id, {sig0, sig1, sig2}));
				value_check(busy_q && !busy, "busy did not fall with done");
			end
		end
		busy_q = busy;
		cyc++;
	end

	a_quiet_before_start: assert property (@(posedge clk) disable iff (rst)
		!started |-> !(busy || done || fault || double_break_start || tx_wr_en || rx_rd_en))
		else proto_fail("outputs active before the first start");

	a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
		tx_wr_en |-> !tx_full)
		else proto_fail("tx_wr_en high while tx_full is high");

	// a fault sends the session back to the double break
	a_break_after_fault: assert property (@(posedge clk) disable iff (rst)
		fault |=> double_break_start)
		else proto_fail("no double break after a fault");

	a_done_not_fault: assert property (@(posedge clk) disable iff (rst)
		!(done && fault))
		else proto_fail("done and fault in the same cycle");

	initial begin
		while (wd_cnt < max_cycles) begin
			@(posedge clk);
			wd_cnt++;
		end
		$display("timeout: the run did not end within %0d cycles", max_cycles);
		report_counts();
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		rst = 1'b1;
		start = 1'b0;
		phy_error = 1'b0;
		tx_full = 1'b0;
		rand_full = 1'b0;
		poll_fails = 0;
		mute_key_status = 1'b0;
		started = 1'b0;
		busy_q = 1'b0;
		rng = 32'h9dca19c3;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		repeat (8) @(negedge clk);

		run_clean(0);

		// NVMPROG mode shows up on the third poll
		poll_fails = 2;
		run_clean(2);
		poll_fails = 0;

		// target drops the key status answer once
		mute_key_status = 1'b1;
		pulse_start();
		wait_fault();
		mute_key_status = 1'b0;
		wait_done();
		value_check(fault_cnt == fault_base + 1,
			$sformatf("%0d faults on a silent response, expected 1", fault_cnt - fault_base));

		// PHY error while the target sits in its reset delay
		pulse_start();
		rst_writes = 0;
		while (rst_writes == 0) begin
			@(negedge clk);
		end
		repeat (3) @(negedge clk);
		phy_error = 1'b1;
		@(negedge clk);
		phy_error = 1'b0;
		wait_fault();
		wait_done();
		value_check(fault_cnt == fault_base + 1,
			$sformatf("%0d faults on a PHY error, expected 1", fault_cnt - fault_base));

		rand_full = 1'b1;
		run_clean(0);
		rand_full = 1'b0;
		repeat (4) @(negedge clk);

		report_counts();
		if (value_errs + proto_errs == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
verilog/updi_pkg.sv
verilog/prog_pkg.sv
verilog/updi_cmd_if.sv
verilog/updi_frame_tx.sv
verilog/updi_frame_rx.sv
verilog/prog_sequencer.sv
verilog/updi_programmer.sv
tests/updi_target_model.sv
tests/tb_updi_programmer.sv

//--- Bender.yml
package:
  name: updi_programmer

sources:
  - verilog/updi_pkg.sv
  - verilog/prog_pkg.sv
  - verilog/updi_cmd_if.sv
  - verilog/updi_frame_tx.sv
  - verilog/updi_frame_rx.sv
  - verilog/prog_sequencer.sv
  - verilog/updi_programmer.sv
  - target: test
    files:
      - tests/updi_target_model.sv
      - tests/tb_updi_programmer.sv
